//--- verilog.f
logic/audio_pkg.sv
logic/i2s_sync.sv
logic/i2s_port.sv
logic/audio_regs.sv
logic/audio_top.sv
tests/audio_chk.sv
tests/tb_audio.sv

//--- run.sh
#!/usr/bin/env bash
# builds the audio interface testbench with Verilator and runs it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_audio \
    --Mdir "$build_dir" \
    -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

"./$build_dir/Vtb_audio"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0

//--- tests/tb_audio.sv
`timescale 1ns/1ps
/*
 * testbench for the audio codec interface
 *   clock, reset and an I2S codec model acting as clock master
 *   AXI4-Lite read and write tasks
 *   directed tests for capture, playback, sticky flags and address errors
 *   watchdog
 */
module tb_audio import audio_pkg::*;;

    localparam int clk_ns     = 20;
    localparam int frame_clks = 32 * 16;    // 32 bit slots of two bclk halves each
    localparam int frame_ns   = frame_clks * clk_ns;
    localparam int num_tests  = 6;
    localparam int timeout_ns = num_tests * 12 * frame_ns + 50000;

    logic                      clk;
    logic                      arst_n;
    logic                      bclk;
    logic                      lrclk;
    logic                      adcda;
    logic                      dacda;
    logic [axi_addr_width-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [axi_data_width-1:0] wdata;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [axi_addr_width-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [axi_data_width-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    // codec model state
    logic [31:0] lcg_state = 32'h5eba_2ac8;
    logic [15:0] send_left;
    logic [15:0] send_right;
    logic [15:0] prev_left;
    logic [15:0] prev_right;
    logic [31:0] frame_bits;
    logic [31:0] play_shift;
    logic [15:0] sent_left;     // last pair whose final bit has gone out on adcda
    logic [15:0] sent_right;
    logic [15:0] played_left;   // last pair rebuilt from dacda
    logic [15:0] played_right;
    int          frames_done;

    audio_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one bclk half period, moves stay 2 ns after a clk edge
    task automatic half_bit();
        repeat (8) @(posedge clk);
        #2;
    endtask

    // I2S master: lrclk low is left, the MSB comes one bit after the lrclk change
    initial begin
        bclk        = 1'b0;
        lrclk       = 1'b1;
        adcda       = 1'b0;
        prev_left   = '0;
        prev_right  = '0;
        play_shift  = '0;
        frames_done = 0;
        forever begin
            lcg_state  = lcg_next(lcg_state);
            send_left  = lcg_state[31:16];
            lcg_state  = lcg_next(lcg_state);
            send_right = lcg_state[31:16];
            frame_bits = {prev_right[0], send_left, send_right[15:1]};
            for (int slot = 0; slot < 32; slot++) begin
                bclk       = 1'b0;
                lrclk      = (slot >= 16);
                adcda      = frame_bits[31];
                frame_bits = frame_bits << 1;
                half_bit();
                bclk       = 1'b1;
                play_shift = {play_shift[30:0], dacda};
                if (slot == 0) begin
                    // the right LSB of the previous frame just went by in both directions
                    sent_left    = prev_left;
                    sent_right   = prev_right;
                    played_left  = play_shift[31:16];
                    played_right = play_shift[15:0];
                    frames_done  = frames_done + 1;
                end
                half_bit();
            end
            prev_left  = send_left;
            prev_right = send_right;
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic axi_write(input logic [axi_addr_width-1:0] addr,
                             input logic [axi_data_width-1:0] data, output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        @(posedge clk);     // bready stays low for one edge, the response has to wait
        #2;
        bready = 1'b1;
        resp   = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [axi_addr_width-1:0] addr,
                            output logic [axi_data_width-1:0] data, output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        @(posedge clk);     // one stalled edge with rready low
        #2;
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [axi_addr_width-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_equal(32'(resp), 32'(resp_okay), "write response");
    endtask

    task automatic read_reg(input logic [axi_addr_width-1:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_equal(32'(resp), 32'(resp_okay), "read response");
    endtask

    // returns 20 clk after the model has finished n more frames
    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) @(posedge clk);
        repeat (20) @(posedge clk);
        #2;
    endtask

    task automatic reset_state();
        logic [31:0] data;
        read_reg(reg_ctrl, data);
        check_equal(data, 32'd0, "CTRL after reset");
        read_reg(reg_status, data);
        check_equal(data, 32'd1 << st_tx_empty, "STATUS after reset");
        repeat (2 * frame_clks) begin
            @(negedge clk);
            check_equal(32'(dacda), 32'd0, "dacda while disabled");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic capture_pair();
        logic [31:0] data;
        logic [31:0] expected;
        write_reg(reg_ctrl, 32'd1 << ctrl_enable);
        read_reg(reg_ctrl, data);
        check_equal(data, 32'd1 << ctrl_enable, "CTRL after enable");
        do begin
            read_reg(reg_status, data);
        end while (!data[st_rx_ready]);
        expected = {sent_right, sent_left};
        read_reg(reg_rx_data, data);
        check_equal(data, expected, "captured pair");
        read_reg(reg_status, data);
        check_equal(32'(data[st_rx_ready]), 32'd0, "rx_ready after RX_DATA read");
    endtask

    task automatic playback_pair();
        logic [31:0] data;
        logic [31:0] pair;
        pair = 32'hbeef_5a3c;
        write_reg(reg_tx_data, pair);
        do begin
            read_reg(reg_status, data);
        end while (!data[st_tx_empty]);
        wait_frames(1);     // the frame that carried our pair has ended
        check_equal({played_right, played_left}, pair, "played pair");
    endtask

    task automatic capture_overflow();
        logic [31:0] data;
        logic [31:0] flags;
        flags = (32'd1 << st_rx_ready) | (32'd1 << st_rx_overflow);
        wait_frames(1);
        read_reg(reg_rx_data, data);
        write_reg(reg_status, 32'd1 << st_rx_overflow);
        read_reg(reg_status, data);
        check_equal(data & flags, 32'd0, "capture flags before overflow");
        wait_frames(2);
        read_reg(reg_status, data);
        check_equal(data & flags, flags, "capture flags after two pairs");
        read_reg(reg_rx_data, data);
        check_equal(data, {sent_right, sent_left}, "pair held after overflow");
        write_reg(reg_status, 32'd1 << st_rx_overflow);
        read_reg(reg_status, data);
        check_equal(data & flags, 32'd0, "capture flags after clear");
    endtask

    task automatic playback_underrun();
        logic [31:0] data;
        logic [31:0] pair;
        pair = 32'h0f1e_c3d2;
        write_reg(reg_tx_data, pair);
        write_reg(reg_status, 32'd1 << st_tx_underrun);
        do begin
            read_reg(reg_status, data);
        end while (!data[st_tx_empty]);
        check_equal(32'(data[st_tx_underrun]), 32'd0, "underrun while a pair was ready");
        wait_frames(1);
        check_equal({played_right, played_left}, pair, "pair before underrun");
        read_reg(reg_status, data);
        check_equal(32'(data[st_tx_underrun]), 32'd1, "underrun without a new write");
        wait_frames(1);
        check_equal({played_right, played_left}, pair, "pair repeated on underrun");
        write_reg(reg_status, 32'd1 << st_tx_underrun);
        read_reg(reg_status, data);
        check_equal(32'(data[st_tx_underrun]), 32'd0, "underrun after clear");
    endtask

    task automatic address_errors();
        logic [31:0] expected;
        logic [31:0] data;
        logic [1:0]  resp;
        wait_frames(1);     // well away from the next captured pair
        expected = {sent_right, sent_left};
        read_reg(reg_rx_data, data);
        check_equal(data, expected, "capture pair before address errors");
        axi_read(4'hE, data, resp);
        check_equal(32'(resp), 32'(resp_slverr), "read of unmapped address");
        axi_write(reg_rx_data, ~expected, resp);
        check_equal(32'(resp), 32'(resp_slverr), "write to RX_DATA");
        axi_write(4'h2, 32'd0, resp);
        check_equal(32'(resp), 32'(resp_slverr), "write to unmapped address");
        read_reg(reg_ctrl, data);
        check_equal(data, 32'd1 << ctrl_enable, "CTRL after address errors");
        read_reg(reg_rx_data, data);
        check_equal(data, expected, "capture pair after address errors");
    endtask

    initial begin
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        reset_state();
        capture_pair();
        playback_pair();
        capture_overflow();
        playback_underrun();
        address_errors();
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired at %0t ns before the tests finished", $time);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

//--- tests/audio_chk.sv
`timescale 1ns/1ps
/*
 * protocol checker for the audio codec interface
 *   AXI4-Lite response valid held until ready
 *   single-cycle capture and playback strobes
 *   playback line quiet while the port is disabled
 */
module audio_chk (
    input logic clk,
    input logic arst_n,
    input logic enable,
    input logic rx_valid,
    input logic tx_load,
    input logic dacda,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid high for more than one cycle");

    a_tx_load_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        tx_load |=> !tx_load)
        else $error("tx_load high for more than one cycle");

    // the port clears dacda one cycle after enable drops
    a_dacda_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !enable |=> !dacda)
        else $error("dacda active while the port is disabled");

endmodule

bind audio_top audio_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .enable   (enable),
    .rx_valid (rx_valid),
    .tx_load  (tx_load),
    .dacda    (dacda),
    .bvalid   (bvalid),
    .bready   (bready),
    .rvalid   (rvalid),
    .rready   (rready)
);

//--- logic/audio_top.sv
`timescale 1ns/1ps
/*
 * audio codec interface top level
 *   codec line synchronizer
 *   I2S capture and playback port
 *   AXI4-Lite register block
 */
module audio_top import audio_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    // codec pins
    input  logic                      bclk,
    input  logic                      lrclk,
    input  logic                      adcda,
    output logic                      dacda,
    // AXI4-Lite slave
    input  logic [axi_addr_width-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [axi_data_width-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [axi_addr_width-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [axi_data_width-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    logic                    bclk_rise;
    logic                    bclk_fall;
    logic                    lrclk_s;
    logic                    adcda_s;
    logic                    enable;
    logic                    rx_valid;
    logic [sample_width-1:0] rx_left;
    logic [sample_width-1:0] rx_right;
    logic                    tx_load;
    logic [sample_width-1:0] tx_left;
    logic [sample_width-1:0] tx_right;

    i2s_sync u_sync (
        .clk       (clk),
        .arst_n    (arst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .adcda     (adcda),
        .bclk_rise (bclk_rise),
        .bclk_fall (bclk_fall),
        .lrclk_s   (lrclk_s),
        .adcda_s   (adcda_s)
    );

    i2s_port u_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .bclk_rise (bclk_rise),
        .bclk_fall (bclk_fall),
        .lrclk_s   (lrclk_s),
        .adcda_s   (adcda_s),
        .tx_left   (tx_left),
        .tx_right  (tx_right),
        .rx_valid  (rx_valid),
        .rx_left   (rx_left),
        .rx_right  (rx_right),
        .tx_load   (tx_load),
        .dacda     (dacda)
    );

    audio_regs u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .rx_valid (rx_valid),
        .rx_left  (rx_left),
        .rx_right (rx_right),
        .tx_load  (tx_load),
        .enable   (enable),
        .tx_left  (tx_left),
        .tx_right (tx_right)
    );

endmodule

//--- logic/audio_regs.sv
`timescale 1ns/1ps
/*
 * AXI4-Lite register block for the audio port
 *   CTRL with the enable bit
 *   STATUS with ready, empty and sticky error flags
 *   RX_DATA capture pair and TX_DATA playback pair
 *   SLVERR for unmapped addresses and writes to RX_DATA
 */
module audio_regs import audio_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [axi_addr_width-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [axi_data_width-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [axi_addr_width-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [axi_data_width-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      rx_valid,
    input  logic [sample_width-1:0]   rx_left,
    input  logic [sample_width-1:0]   rx_right,
    input  logic                      tx_load,
    output logic                      enable,
    output logic [sample_width-1:0]   tx_left,
    output logic [sample_width-1:0]   tx_right
);

    logic                      wr_en;
    logic                      rd_en;
    logic                      wr_ctrl;
    logic                      wr_status;
    logic                      wr_tx;
    logic                      rd_rx;
    axi_resp_e                 wr_resp;
    axi_resp_e                 rd_resp;
    logic [axi_data_width-1:0] rd_word;
    logic [axi_data_width-1:0] status_word;
    logic                      rx_ready;
    logic                      rx_overflow;
    logic                      tx_empty;
    logic                      tx_underrun;
    logic [sample_width-1:0]   rx_pair_left;
    logic [sample_width-1:0]   rx_pair_right;

    // address and data are taken together, only with no write response pending
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;

    assign arready = !rvalid;
    assign rd_en   = arvalid && arready;

    // write decode
    always_comb begin
        wr_ctrl   = 1'b0;
        wr_status = 1'b0;
        wr_tx     = 1'b0;
        wr_resp   = resp_okay;
        case (awaddr)
            reg_ctrl:    wr_ctrl   = wr_en;
            reg_status:  wr_status = wr_en;
            reg_tx_data: wr_tx     = wr_en;
            default:     wr_resp   = resp_slverr;   // RX_DATA is read only
        endcase
    end

    always_comb begin
        status_word                 = '0;
        status_word[st_rx_ready]    = rx_ready;
        status_word[st_rx_overflow] = rx_overflow;
        status_word[st_tx_empty]    = tx_empty;
        status_word[st_tx_underrun] = tx_underrun;
    end

    // read decode
    always_comb begin
        rd_rx   = 1'b0;
        rd_word = '0;
        rd_resp = resp_okay;
        case (araddr)
            reg_ctrl:    rd_word[ctrl_enable] = enable;
            reg_status:  rd_word = status_word;
            reg_rx_data: begin
                rd_word = {rx_pair_right, rx_pair_left};
                rd_rx   = rd_en;
            end
            reg_tx_data: rd_word = {tx_right, tx_left};
            default:     rd_resp = resp_slverr;
        endcase
    end

    // response handshakes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bresp <= wr_resp;
        end
        if (rd_en) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // registers and flags, a new event wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable        <= 1'b0;
            rx_ready      <= 1'b0;
            rx_overflow   <= 1'b0;
            tx_empty      <= 1'b1;
            tx_underrun   <= 1'b0;
            rx_pair_left  <= '0;
            rx_pair_right <= '0;
            tx_left       <= '0;
            tx_right      <= '0;
        end else begin
            if (wr_ctrl) begin
                enable <= wdata[ctrl_enable];
            end

            if (rx_valid) begin
                rx_ready      <= 1'b1;
                rx_pair_left  <= rx_left;   // a pair never read is replaced
                rx_pair_right <= rx_right;
            end else if (rd_rx) begin
                rx_ready <= 1'b0;
            end
            // a read on the same edge still gets the old pair, so nothing is lost
            if (rx_valid && rx_ready && !rd_rx) begin
                rx_overflow <= 1'b1;
            end else if (wr_status && wdata[st_rx_overflow]) begin
                rx_overflow <= 1'b0;
            end

            if (wr_tx) begin
                tx_empty <= 1'b0;
                tx_left  <= wdata[sample_width-1:0];
                tx_right <= wdata[2*sample_width-1:sample_width];
            end else if (tx_load) begin
                tx_empty <= 1'b1;
            end
            if (tx_load && tx_empty) begin
                tx_underrun <= 1'b1;                // port replays the held pair
            end else if (wr_status && wdata[st_tx_underrun]) begin
                tx_underrun <= 1'b0;
            end
        end
    end

endmodule

//--- logic/i2s_port.sv
`timescale 1ns/1ps
/*
 * I2S port, codec is the clock master
 *   capture deserializer with word select boundary detection
 *   left/right pair output with a valid strobe
 *   playback serializer loading a new pair at each left word
 */
module i2s_port import audio_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    enable,
    input  logic                    bclk_rise,
    input  logic                    bclk_fall,
    input  logic                    lrclk_s,
    input  logic                    adcda_s,
    input  logic [sample_width-1:0] tx_left,
    input  logic [sample_width-1:0] tx_right,
    output logic                    rx_valid,
    output logic [sample_width-1:0] rx_left,
    output logic [sample_width-1:0] rx_right,
    output logic                    tx_load,
    output logic                    dacda
);

    logic                    lrclk_prev;    // word select seen at the previous bclk rise
    logic                    framed;        // a boundary has passed since enable went high
    logic                    left_seen;     // a complete left word waits for its right word
    logic                    boundary;
    logic [sample_width-1:0] rx_shift;
    logic [sample_width-1:0] rx_word;
    logic [sample_width-1:0] rx_left_hold;
    logic [sample_width-1:0] tx_shift;
    logic [sample_width-1:0] tx_right_hold;

    // in I2S the word select changes one bit before the MSB, so the rise
    // where it differs from the last one samples the LSB of the old word
    assign boundary = enable && bclk_rise && (lrclk_s != lrclk_prev);
    assign rx_word  = {rx_shift[sample_width-2:0], adcda_s};

    // the register block sees the strobe on the edge where the pair is copied
    assign tx_load  = boundary && !lrclk_s;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lrclk_prev <= 1'b0;
            framed     <= 1'b0;
            left_seen  <= 1'b0;
            rx_valid   <= 1'b0;
            dacda      <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!enable) begin
                // keep tracking word select so enabling mid-word gives no false boundary
                lrclk_prev <= lrclk_s;
                framed     <= 1'b0;
                left_seen  <= 1'b0;
                dacda      <= 1'b0;
            end else begin
                if (bclk_rise) begin
                    lrclk_prev <= lrclk_s;
                end
                if (boundary) begin
                    framed <= 1'b1;
                    if (!lrclk_prev) begin
                        left_seen <= framed;    // the first word after enable is partial
                    end else begin
                        rx_valid  <= left_seen;
                        left_seen <= 1'b0;
                    end
                end
                if (bclk_fall) begin
                    dacda <= tx_shift[sample_width-1];  // MSB first
                end
            end
        end
    end

    // shift registers and sample holding
    always_ff @(posedge clk) begin
        if (!enable) begin
            rx_shift <= '0;
            tx_shift <= '0;
        end else begin
            if (bclk_rise) begin
                rx_shift <= rx_word;
            end

            if (boundary) begin
                // the finished word belongs to the channel that just ended
                if (!lrclk_prev) begin
                    rx_left_hold <= rx_word;
                end else begin
                    rx_left  <= rx_left_hold;
                    rx_right <= rx_word;
                end

                // load the word for the channel that starts now
                if (!lrclk_s) begin
                    tx_shift      <= tx_left;
                    tx_right_hold <= tx_right;  // right half of the copied pair
                end else begin
                    tx_shift      <= tx_right_hold;
                end
            end else if (bclk_fall) begin
                tx_shift <= {tx_shift[sample_width-2:0], 1'b0};
            end
        end
    end

endmodule

//--- logic/i2s_sync.sv
`timescale 1ns/1ps
/*
 * synchronizer for the codec clock domain
 *   two-flop synchronizers for bclk, lrclk and adcda
 *   registered bclk rise and fall strobes
 *   word select and data delayed to line up with the strobes
 */
module i2s_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic bclk,
    input  logic lrclk,
    input  logic adcda,
    output logic bclk_rise,
    output logic bclk_fall,
    output logic lrclk_s,
    output logic adcda_s
);

    logic [1:0] bclk_sync;      // index 1 is the settled value
    logic [1:0] lrclk_sync;
    logic [1:0] adcda_sync;
    logic       bclk_d;         // settled bclk one cycle later, for edge detection

    // a raw bclk edge shows up on the strobes three clk cycles later.
    // lrclk and adcda get a third stage so they still match the bclk
    // level that produced the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            adcda_sync <= '0;
            bclk_d     <= 1'b0;
            bclk_rise  <= 1'b0;
            bclk_fall  <= 1'b0;
            lrclk_s    <= 1'b0;
            adcda_s    <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            adcda_sync <= {adcda_sync[0], adcda};
            bclk_d     <= bclk_sync[1];
            bclk_rise  <= bclk_sync[1] & ~bclk_d;
            bclk_fall  <= ~bclk_sync[1] & bclk_d;
            lrclk_s    <= lrclk_sync[1];    // third stage, same as the strobes
            adcda_s    <= adcda_sync[1];
        end
    end

endmodule

//--- logic/audio_pkg.sv
/*
 * shared definitions for the audio codec interface
 *   sample and AXI4-Lite widths
 *   register map and response codes
 *   STATUS and CTRL bit positions
 */
package audio_pkg;

    // one audio word per channel, left and right share a 32-bit register
    localparam int sample_width   = 16;

    localparam int axi_addr_width = 4;
    localparam int axi_data_width = 32;

    // byte addresses of the register block
    typedef enum logic [axi_addr_width-1:0] {
        reg_ctrl    = 4'h0,
        reg_status  = 4'h4,
        reg_rx_data = 4'h8,     // read only, left in 15:0 and right in 31:16
        reg_tx_data = 4'hC      // same packing as the capture register
    } reg_addr_e;

    // STATUS bits
    localparam int st_rx_ready    = 0;
    localparam int st_rx_overflow = 1;  // sticky, write one to clear
    localparam int st_tx_empty    = 2;
    localparam int st_tx_underrun = 3;  // sticky, write one to clear

    // CTRL bits
    localparam int ctrl_enable    = 0;

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } axi_resp_e;

endpackage
